// File: Makefile
# Verilator build and run of the USB3300 sniffer testbench

TOP       ?= sniffer_tb
SEED_ARGS ?= +verilator+seed+1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f

run: build
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation did not pass"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f build.f

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
logic/sniffer_pkg.sv
logic/uart_link.sv
logic/host_cmd_stack.sv
logic/ulpi_link.sv
logic/sniff_controller.sv
logic/usb3300_sniffer.sv
sim/sniffer_props.sv
sim/sniffer_tb.sv

// File: logic/host_cmd_stack.sv
// Host command stack
// Pairs UART bytes into commands and queues them for the controller
`timescale 1ns/1ps

module host_cmd_stack #(
    parameter int CMD_DEPTH = sniffer_pkg::CMD_DEPTH_DEF // Power of two
) (
    input  logic                  clk_ulpi,
    input  logic                  arst_n,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_valid,
    output sniffer_pkg::host_cmd_t cmd,
    output logic                  cmd_empty,
    input  logic                  cmd_pull
);

    localparam int AW = $clog2(CMD_DEPTH);

    sniffer_pkg::host_cmd_t mem [CMD_DEPTH];

    logic [7:0]  half;            // {op, addr} of pending pair
    logic        phase;           // High once first byte is in
    logic [AW:0] wr_ptr, rd_ptr;  // Extra bit tells full from empty
    logic        full;
    logic        push;
    logic        pop;

    assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign cmd_empty = (wr_ptr == rd_ptr);

    assign push = rx_valid && phase && !full; // Pair lost when full
    assign pop  = cmd_pull && !cmd_empty;

    always_ff @(posedge clk_ulpi or negedge arst_n) begin
        if (!arst_n) begin
            phase  <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (rx_valid)
                phase <= !phase;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_ulpi) begin
        if (rx_valid && !phase)
            half <= rx_byte;
        if (push)
            mem[wr_ptr[AW-1:0]] <= sniffer_pkg::host_cmd_t'({half, rx_byte});
    end

    assign cmd = mem[rd_ptr[AW-1:0]]; // Valid while not empty

endmodule

// File: logic/sniff_controller.sv
// Sniffer controller
// Runs host commands, owns capture enable and frames
// register values and captured bytes for the UART
`timescale 1ns/1ps

module sniff_controller (
    input  logic                   clk_ulpi,
    input  logic                   arst_n,
    input  sniffer_pkg::host_cmd_t cmd,
    input  logic                   cmd_empty,
    output logic                   cmd_pull,
    output sniffer_pkg::reg_req_t  reg_req,
    output logic                   reg_start,
    input  logic                   reg_busy,
    input  logic [7:0]             reg_rdata,
    output logic                   capture_en,
    input  sniffer_pkg::cap_item_t cap_item,
    input  logic                   cap_empty,
    output logic                   cap_pull,
    output logic [7:0]             tx_byte,
    output logic                   tx_send,
    input  logic                   tx_busy
);

    typedef enum logic [2:0] {
        C_IDLE,
        C_REQ,   // Hand register access to ULPI link
        C_WAIT,  // Register access in flight
        C_TAG,
        C_VAL
    } ctrl_state_e;

    ctrl_state_e            state;
    sniffer_pkg::host_cmd_t cmd_q;
    logic [7:0]             tag_q;   // Frame being sent
    logic [7:0]             val_q;

    // Commands before captured items
    assign cmd_pull  = (state == C_IDLE) && !cmd_empty;
    assign cap_pull  = (state == C_IDLE) && cmd_empty && !cap_empty;
    assign reg_start = (state == C_REQ) && !reg_busy;
    assign tx_send   = (state == C_TAG || state == C_VAL) && !tx_busy;
    assign tx_byte   = (state == C_TAG) ? tag_q : val_q;

    always_comb begin
        reg_req.write = (cmd_q.op == sniffer_pkg::OP_REG_WRITE);
        reg_req.addr  = cmd_q.addr;
        reg_req.value = cmd_q.value;
    end

    always_ff @(posedge clk_ulpi or negedge arst_n) begin
        if (!arst_n) begin
            state      <= C_IDLE;
            capture_en <= 1'b0;
        end else begin
            case (state)
                C_IDLE: if (!cmd_empty) begin
                    case (cmd.op)
                        sniffer_pkg::OP_CAPTURE_ON:  capture_en <= 1'b1;
                        sniffer_pkg::OP_CAPTURE_OFF: capture_en <= 1'b0;
                        default:                     state <= C_REQ;
                    endcase
                end else if (!cap_empty) begin
                    state <= C_TAG;
                end
                C_REQ:  if (!reg_busy) state <= C_WAIT;
                // Busy is already up on entry
                C_WAIT: if (!reg_busy) state <= reg_req.write ? C_IDLE : C_TAG;
                C_TAG:  if (!tx_busy) state <= C_VAL; // Busy rises next cycle
                C_VAL:  if (!tx_busy) state <= C_IDLE;
                default: state <= C_IDLE;
            endcase
        end
    end

    // Command and frame payload
    always_ff @(posedge clk_ulpi) begin
        if (cmd_pull)
            cmd_q <= cmd;
        if (cap_pull) begin
            tag_q <= cap_item.is_cmd ? sniffer_pkg::TAG_RXCMD : sniffer_pkg::TAG_DATA;
            val_q <= cap_item.rx_byte.data;
        end else if (state == C_WAIT && !reg_busy) begin
            tag_q <= sniffer_pkg::TAG_REG;
            val_q <= reg_rdata; // Valid as busy drops
        end
    end

endmodule

// File: logic/sniffer_pkg.sv
// USB3300 sniffer shared definitions
// Parameter defaults, host opcodes, frame tags and the ULPI byte types
package sniffer_pkg;

    localparam int BAUD_DIV_DEF  = 65;  // 921600 baud at 60 MHz
    localparam int CMD_DEPTH_DEF = 4;   // Host command queue entries
    localparam int CAP_DEPTH_DEF = 16;  // Capture buffer entries

    // Host opcodes, top two bits of the first command byte
    typedef enum logic [1:0] {
        OP_REG_WRITE   = 2'b00,
        OP_REG_READ    = 2'b01,
        OP_CAPTURE_ON  = 2'b10,
        OP_CAPTURE_OFF = 2'b11
    } host_op_e;

    typedef struct packed {
        host_op_e    op;
        logic [5:0]  addr;   // PHY register address
        logic [7:0]  value;  // Write data, ignored otherwise
    } host_cmd_t;

    // ULPI RX CMD byte, MSB first
    typedef struct packed {
        logic        id;
        logic        host_disconnect;
        logic        rx_error;
        logic        rx_active;
        logic [1:0]  vbus_state;
        logic [1:0]  line_state;
    } rx_cmd_t;

    // Byte turned around by the PHY, status or USB payload
    typedef union packed {
        rx_cmd_t     cmd;
        logic [7:0]  data;
    } ulpi_rx_byte_u;

    typedef struct packed {
        logic          is_cmd;  // nxt was low
        ulpi_rx_byte_u rx_byte;
    } cap_item_t;

    typedef struct packed {
        logic        write;  // Low for a read
        logic [5:0]  addr;
        logic [7:0]  value;
    } reg_req_t;

    // First byte of each host frame
    localparam logic [7:0] TAG_DATA  = 8'hD0;
    localparam logic [7:0] TAG_RXCMD = 8'hC0;
    localparam logic [7:0] TAG_REG   = 8'hE0;

    // ULPI TX CMD prefixes
    localparam logic [1:0] TXCMD_REG_WRITE = 2'b10;
    localparam logic [1:0] TXCMD_REG_READ  = 2'b11;

endpackage

// File: logic/uart_link.sv
// UART link, 8N1
// Receiver samples mid-bit and drops frames with a bad stop bit
// Transmitter shifts out one frame per tx_send
`timescale 1ns/1ps

module uart_link #(
    parameter int BAUD_DIV = sniffer_pkg::BAUD_DIV_DEF
) (
    input  logic       clk_ulpi,
    input  logic       arst_n,
    input  logic       rx,
    output logic       tx,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    input  logic [7:0] tx_byte,
    input  logic       tx_send,
    output logic       tx_busy
);

    localparam int CW = $clog2(BAUD_DIV + 1);

    logic [1:0]    rx_sync;   // Metastability guard
    logic          rx_busy;
    logic [CW-1:0] rx_cnt;
    logic [3:0]    rx_idx;    // 0 start, 1..8 data, 9 stop
    logic [7:0]    rx_shift;

    logic [CW-1:0] tx_cnt;
    logic [3:0]    tx_idx;
    logic [9:0]    tx_shift;  // Stop, data, start

    // Receiver
    always_ff @(posedge clk_ulpi or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync  <= 2'b11;
            rx_busy  <= 1'b0;
            rx_cnt   <= '0;
            rx_idx   <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx};
            rx_valid <= 1'b0;
            if (!rx_busy) begin
                if (!rx_sync[1]) begin // Falling edge of start bit
                    rx_busy <= 1'b1;
                    rx_cnt  <= CW'(BAUD_DIV / 2); // Half a bit to mid-point
                    rx_idx  <= '0;
                end
            end else if (rx_cnt != '0) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt <= CW'(BAUD_DIV - 1);
                rx_idx <= rx_idx + 1'b1;
                if (rx_idx == 4'd0) begin
                    if (rx_sync[1])
                        rx_busy <= 1'b0; // Glitch, not a start bit
                end else if (rx_idx == 4'd9) begin
                    rx_busy  <= 1'b0;
                    rx_valid <= rx_sync[1]; // Framing error drops byte
                end
            end
        end
    end

    // Data bits, LSB first
    always_ff @(posedge clk_ulpi) begin
        if (rx_busy && rx_cnt == '0 && rx_idx != 4'd0 && rx_idx != 4'd9)
            rx_shift <= {rx_sync[1], rx_shift[7:1]};
    end

    assign rx_byte = rx_shift;

    // Transmitter
    always_ff @(posedge clk_ulpi or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy  <= 1'b0;
            tx_cnt   <= '0;
            tx_idx   <= '0;
            tx_shift <= '1; // Line idles high
        end else if (!tx_busy) begin
            if (tx_send) begin
                tx_busy  <= 1'b1;
                tx_cnt   <= CW'(BAUD_DIV - 1);
                tx_idx   <= '0;
                tx_shift <= {1'b1, tx_byte, 1'b0};
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 1'b1;
        end else if (tx_idx == 4'd9) begin
            tx_busy <= 1'b0; // End of stop bit
        end else begin
            tx_cnt   <= CW'(BAUD_DIV - 1);
            tx_idx   <= tx_idx + 1'b1;
            tx_shift <= {1'b1, tx_shift[9:1]};
        end
    end

    assign tx = tx_shift[0];

endmodule

// File: logic/ulpi_link.sv
// ULPI link layer
// Runs register write/read transactions and buffers every byte
// the PHY turns around while capture is enabled
`timescale 1ns/1ps

module ulpi_link #(
    parameter int CAP_DEPTH = sniffer_pkg::CAP_DEPTH_DEF
) (
    input  logic                   clk_ulpi,
    input  logic                   arst_n,
    input  logic                   dir,
    input  logic                   nxt,
    input  logic [7:0]             rx_data,
    output logic [7:0]             tx_data,
    output logic                   drive,
    output logic                   stp,
    input  sniffer_pkg::reg_req_t  reg_req,
    input  logic                   reg_start,
    output logic                   reg_busy,
    output logic [7:0]             reg_rdata,
    input  logic                   capture_en,
    output sniffer_pkg::cap_item_t cap_item,
    output logic                   cap_empty,
    input  logic                   cap_pull
);

    localparam int CAW = (CAP_DEPTH > 1) ? $clog2(CAP_DEPTH) : 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_CMD,      // TX CMD on the bus
        S_VALUE,    // Write data on the bus
        S_STOP,
        S_TURN,     // Read turnaround
        S_RDATA,
        S_RELEASE   // Wait for PHY to hand the bus back
    } link_state_e;

    link_state_e           state;
    sniffer_pkg::reg_req_t req_q;
    logic                  drive_en;
    logic                  dir_q;

    sniffer_pkg::cap_item_t cap_mem [CAP_DEPTH];
    sniffer_pkg::cap_item_t cap_wr;
    logic [CAW-1:0]         cap_wp, cap_rp;
    logic [CAW:0]           cap_cnt;
    logic                   cap_push, do_push, do_pop;

    // Link owns the data bus
    assign drive = drive_en;

    always_ff @(posedge clk_ulpi or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            drive_en <= 1'b0;
            tx_data  <= '0;
            stp      <= 1'b0;
            reg_busy <= 1'b0;
            dir_q    <= 1'b0;
        end else begin
            dir_q <= dir;
            stp   <= 1'b0;
            case (state)
                S_IDLE: if (reg_start) begin
                    reg_busy <= 1'b1;
                    tx_data  <= {reg_req.write ? sniffer_pkg::TXCMD_REG_WRITE
                                               : sniffer_pkg::TXCMD_REG_READ,
                                 reg_req.addr};
                    state    <= S_CMD;
                end
                S_CMD: if (!drive_en) begin
                    drive_en <= !dir; // Start once the PHY is off the bus
                end else if (nxt && !dir) begin // PHY took the TX CMD
                    if (req_q.write) begin
                        tx_data <= req_q.value;
                        state   <= S_VALUE;
                    end else begin
                        drive_en <= 1'b0;
                        tx_data  <= '0;
                        state    <= S_TURN;
                    end
                end
                S_VALUE: if (nxt) begin
                    tx_data <= '0;
                    stp     <= 1'b1; // Single cycle
                    state   <= S_STOP;
                end
                S_STOP: begin
                    drive_en <= 1'b0;
                    reg_busy <= 1'b0;
                    state    <= S_IDLE;
                end
                S_TURN:    if (dir) state <= S_RDATA; // Skip turnaround cycle
                S_RDATA:   state <= S_RELEASE;
                S_RELEASE: if (!dir) begin
                    reg_busy <= 1'b0;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_ulpi) begin
        if (state == S_IDLE && reg_start)
            req_q <= reg_req;
        if (state == S_RDATA)
            reg_rdata <= rx_data; // Held until next read
    end

    // Capture, only on PHY-driven cycles past the turnaround
    assign cap_push = dir && dir_q && capture_en && (state != S_RDATA);
    assign do_push  = cap_push && (cap_cnt != (CAW+1)'(CAP_DEPTH)); // Full drops
    assign do_pop   = cap_pull && !cap_empty;
    assign cap_empty = (cap_cnt == '0);

    always_comb begin
        cap_wr.is_cmd       = !nxt;   // nxt low marks an RX CMD
        cap_wr.rx_byte.data = rx_data;
    end

    always_ff @(posedge clk_ulpi or negedge arst_n) begin
        if (!arst_n) begin
            cap_wp  <= '0;
            cap_rp  <= '0;
            cap_cnt <= '0;
        end else begin
            if (do_push)
                cap_wp <= (cap_wp == CAW'(CAP_DEPTH - 1)) ? '0 : cap_wp + 1'b1;
            if (do_pop)
                cap_rp <= (cap_rp == CAW'(CAP_DEPTH - 1)) ? '0 : cap_rp + 1'b1;
            cap_cnt <= cap_cnt + (CAW+1)'(do_push) - (CAW+1)'(do_pop);
        end
    end

    always_ff @(posedge clk_ulpi) begin
        if (do_push)
            cap_mem[cap_wp] <= cap_wr;
    end

    assign cap_item = cap_mem[cap_rp];

endmodule

// File: logic/usb3300_sniffer.sv
// USB3300 sniffer top level
// UART command link, command queue, controller and ULPI link
`timescale 1ns/1ps

module usb3300_sniffer #(
    parameter int BAUD_DIV  = sniffer_pkg::BAUD_DIV_DEF,
    parameter int CMD_DEPTH = sniffer_pkg::CMD_DEPTH_DEF,
    parameter int CAP_DEPTH = sniffer_pkg::CAP_DEPTH_DEF
) (
    input  logic       clk_ulpi,      // 60 MHz from the PHY
    input  logic       arst_n,
    input  logic       uart_rx,
    output logic       uart_tx,
    input  logic       ulpi_dir,
    input  logic       ulpi_nxt,
    input  logic [7:0] ulpi_rx_data,
    output logic [7:0] ulpi_tx_data,
    output logic       ulpi_drive,    // Output enable of the data pins
    output logic       ulpi_stp
);

    logic [7:0]             rx_byte;
    logic                   rx_valid;
    logic [7:0]             tx_byte;
    logic                   tx_send, tx_busy;
    sniffer_pkg::host_cmd_t cmd;
    logic                   cmd_empty, cmd_pull;
    sniffer_pkg::reg_req_t  reg_req;
    logic                   reg_start, reg_busy;
    logic [7:0]             reg_rdata;
    logic                   capture_en;
    sniffer_pkg::cap_item_t cap_item;
    logic                   cap_empty, cap_pull;

    uart_link #(.BAUD_DIV(BAUD_DIV)) i_uart (
        .clk_ulpi (clk_ulpi),  .arst_n  (arst_n),
        .rx       (uart_rx),   .tx      (uart_tx),
        .rx_byte  (rx_byte),   .rx_valid(rx_valid),
        .tx_byte  (tx_byte),   .tx_send (tx_send),
        .tx_busy  (tx_busy)
    );

    host_cmd_stack #(.CMD_DEPTH(CMD_DEPTH)) i_cmd_stack (
        .clk_ulpi (clk_ulpi),  .arst_n   (arst_n),
        .rx_byte  (rx_byte),   .rx_valid (rx_valid),
        .cmd      (cmd),       .cmd_empty(cmd_empty),
        .cmd_pull (cmd_pull)
    );

    sniff_controller i_ctrl (
        .clk_ulpi  (clk_ulpi),   .arst_n    (arst_n),
        .cmd       (cmd),        .cmd_empty (cmd_empty),  .cmd_pull(cmd_pull),
        .reg_req   (reg_req),    .reg_start (reg_start),  .reg_busy(reg_busy),
        .reg_rdata (reg_rdata),  .capture_en(capture_en),
        .cap_item  (cap_item),   .cap_empty (cap_empty),  .cap_pull(cap_pull),
        .tx_byte   (tx_byte),    .tx_send   (tx_send),    .tx_busy (tx_busy)
    );

    ulpi_link #(.CAP_DEPTH(CAP_DEPTH)) i_ulpi (
        .clk_ulpi  (clk_ulpi),     .arst_n   (arst_n),
        .dir       (ulpi_dir),     .nxt      (ulpi_nxt),
        .rx_data   (ulpi_rx_data), .tx_data  (ulpi_tx_data),
        .drive     (ulpi_drive),   .stp      (ulpi_stp),
        .reg_req   (reg_req),      .reg_start(reg_start),
        .reg_busy  (reg_busy),     .reg_rdata(reg_rdata),
        .capture_en(capture_en),   .cap_item (cap_item),
        .cap_empty (cap_empty),    .cap_pull (cap_pull)
    );

endmodule

// File: sim/sniffer_golden.txt
# Columns: W addr value | R addr expected | C on/off | P count b0..b3 | E frames name
# Addresses and bytes in hex, counts in decimal
E 0 reset_state
W 16 5a
R 16 5a
E 1 reg_write_read
C on
P 3 a5 3c 7e
E 5 capture_on
C off
P 2 11 22
E 0 capture_off
C on
P 1 c3
R 16 5a
E 4 reg_after_capture
C off
W 0a 81
R 0a 81
E 1 reg_second_addr

// File: sim/sniffer_props.sv
// Protocol properties for the ULPI and UART links
// Bound into both link blocks, unused inputs tied off per bind
`timescale 1ns/1ps

module sniffer_props (
    input logic clk,
    input logic arst_n,
    input logic stp,
    input logic drive,
    input logic dir,
    input logic tx
);

    // stp is a single-cycle strobe
    a_stp_single: assert property (@(posedge clk) disable iff (!arst_n) stp |=> !stp)
        else $error("ULPI stp held high for two cycles");

    // No bus contention with the PHY
    a_no_contention: assert property (@(posedge clk) disable iff (!arst_n) !(drive && dir))
        else $error("ULPI link drives data while PHY owns the bus");

    // Line idle from the first reset edge on
    a_tx_idle_reset: assert property (@(posedge clk) !arst_n |=> tx)
        else $error("UART tx not idle during reset");

endmodule

bind ulpi_link sniffer_props i_props (
    .clk(clk_ulpi), .arst_n(arst_n), .stp(stp), .drive(drive), .dir(dir), .tx(1'b1)
);

bind uart_link sniffer_props i_props (
    .clk(clk_ulpi), .arst_n(arst_n), .stp(1'b0), .drive(1'b0), .dir(1'b0), .tx(tx)
);

// File: sim/sniffer_tb.sv
// USB3300 sniffer testbench
// PHY and UART host models, golden-file driven tests
`timescale 1ns/1ps

module sniffer_tb;

    localparam int BAUD = 8;
    localparam int QUIET = 400;           // Cycles with no frame expected
    localparam logic [7:0] RXCMD_OPEN  = 8'h11; // rx_active, line state J
    localparam logic [7:0] RXCMD_CLOSE = 8'h01;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    logic uart_rx = 1'b1;
    logic ulpi_dir = 1'b0;
    logic ulpi_nxt = 1'b0;
    logic [7:0] ulpi_rx_data = 8'h00;
    wire uart_tx, ulpi_drive, ulpi_stp;
    wire [7:0] ulpi_tx_data;

    logic [7:0] phy_regs [64];
    logic [8:0] pkt_q[$];                 // {nxt, byte}
    logic [7:0] rx_q[$];                  // Bytes from the DUT
    logic [7:0] exp_q[$];
    int phy_state = 0;
    logic [5:0] phy_addr;
    int errors = 0, test_errs = 0, tests = 0;
    bit abort = 0;

    usb3300_sniffer #(.BAUD_DIV(BAUD), .CMD_DEPTH(4), .CAP_DEPTH(16)) i_dut (
        .clk_ulpi(clk), .arst_n(arst_n), .uart_rx(uart_rx), .uart_tx(uart_tx),
        .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt), .ulpi_rx_data(ulpi_rx_data),
        .ulpi_tx_data(ulpi_tx_data), .ulpi_drive(ulpi_drive), .ulpi_stp(ulpi_stp)
    );

    always #5 clk = ~clk;

    // PHY model, acts on falling edges
    always @(negedge clk) begin
        if (arst_n) begin
            case (phy_state)
                0: if (ulpi_drive && ulpi_tx_data[7:6] == sniffer_pkg::TXCMD_REG_WRITE) begin
                    ulpi_nxt = 1'b1;
                    phy_addr = ulpi_tx_data[5:0];
                    phy_state = 1;
                end else if (ulpi_drive && ulpi_tx_data[7:6] == sniffer_pkg::TXCMD_REG_READ) begin
                    ulpi_nxt = 1'b1;
                    phy_addr = ulpi_tx_data[5:0];
                    phy_state = 3;
                end else if (pkt_q.size() > 0) begin
                    ulpi_dir = 1'b1;          // Turnaround cycle
                    phy_state = 6;
                end
                1: begin
                    phy_regs[phy_addr] = ulpi_tx_data; // Write value now on bus
                    phy_state = 2;
                end
                2: begin
                    check("ulpi stp after write", 1, ulpi_stp);
                    check("ulpi data during stp", 0, ulpi_tx_data);
                    ulpi_nxt = 1'b0;
                    phy_state = 0;
                end
                3: begin
                    ulpi_nxt = 1'b0;
                    ulpi_dir = 1'b1;
                    phy_state = 4;
                end
                4: begin
                    ulpi_rx_data = phy_regs[phy_addr];
                    phy_state = 5;
                end
                5: begin
                    ulpi_dir = 1'b0;
                    ulpi_rx_data = 8'h00;
                    phy_state = 0;
                end
                6: if (pkt_q.size() > 0) begin
                    {ulpi_nxt, ulpi_rx_data} = pkt_q.pop_front();
                end else begin
                    ulpi_dir = 1'b0;
                    ulpi_nxt = 1'b0;
                    ulpi_rx_data = 8'h00;
                    phy_state = 0;
                end
                default: phy_state = 0;
            endcase
        end
    end

    // Host UART receiver, mid-bit sampling on falling edges
    int mon_cnt = 0, mon_idx = 0;
    bit mon_busy = 0;
    logic [7:0] mon_shift;
    always @(negedge clk) begin
        if (!mon_busy) begin
            if (arst_n && !uart_tx) begin
                mon_busy = 1;
                mon_cnt = BAUD / 2 - 1;
                mon_idx = 0;
            end
        end else if (mon_cnt > 0) begin
            mon_cnt--;
        end else begin
            mon_cnt = BAUD - 1;
            if (mon_idx == 0 && uart_tx) begin
                mon_busy = 0;
            end else if (mon_idx >= 1 && mon_idx <= 8) begin
                mon_shift = {uart_tx, mon_shift[7:1]};
            end else if (mon_idx == 9) begin
                mon_busy = 0;
                if (uart_tx) begin
                    rx_q.push_back(mon_shift);
                end else begin
                    $display("ERROR host saw a UART frame with a low stop bit");
                    errors++;
                end
            end
            mon_idx++;
        end
    end

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %0h actual %0h", what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            uart_rx = bits[i];
            repeat (BAUD - 1) @(negedge clk);
        end
    endtask

    task automatic idle_gap();
        repeat (20 + $urandom % 30) @(negedge clk);
    endtask

    task automatic send_cmd(input sniffer_pkg::host_op_e op, input logic [5:0] a,
                            input logic [7:0] v);
        send_byte({op, a});
        send_byte(v);
        idle_gap();
    endtask

    // Waits until the host holds at least n bytes
    task automatic wait_bytes(input int n, input string what);
        int t;
        for (t = 0; t < 400 * (n + 1) && rx_q.size() < n; t++)
            @(negedge clk);
        if (rx_q.size() < n) begin
            $display("ERROR timeout in %s, only %0d of %0d bytes came back",
                     what, rx_q.size(), n);
            errors++;
            abort = 1;
        end
    endtask

    task automatic wait_phy_idle();
        int t;
        for (t = 0; t < 200 && (phy_state != 0 || pkt_q.size() > 0); t++)
            @(negedge clk);
        if (phy_state != 0 || pkt_q.size() > 0) begin
            $display("ERROR timeout, PHY model never finished its packet");
            errors++;
            abort = 1;
        end
    endtask

    task automatic finish_test(input string name, input int frames);
        int got;
        if (frames > 0)
            wait_bytes(2 * frames, name);
        repeat (QUIET) @(negedge clk);  // Catch stray frames
        got = rx_q.size();
        check({name, " byte count"}, 2 * frames, got);
        while (rx_q.size() > 0 && exp_q.size() > 0)
            check({name, " frame byte"}, exp_q.pop_front(), rx_q.pop_front());
        rx_q.delete();
        exp_q.delete();
        tests++;
        $display("test %s %s (%0d errors)", name, test_errs == 0 ? "ok" : "bad", test_errs);
        test_errs = 0;
    endtask

    initial begin
        int fd, n, a, v;
        logic [7:0] pb [4];
        string line, tok, tname;
        bit cap_on;
        void'($urandom(32'hdcb6));
        cap_on = 0;
        for (int i = 0; i < 64; i++)
            phy_regs[i] = 8'(i * 7) ^ 8'ha5;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check("reset_state uart_tx", 1, uart_tx);
        check("reset_state ulpi_stp", 0, ulpi_stp);
        check("reset_state ulpi_drive", 0, ulpi_drive);
        check("reset_state ulpi_tx_data", 0, ulpi_tx_data);
        fd = $fopen("sim/sniffer_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR cannot open the golden stimulus file");
            errors++;
            abort = 1;
        end
        while (!abort && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 1)
                continue;
            case (line.getc(0))
                "W": begin
                    void'($sscanf(line, "W %h %h", a, v));
                    send_cmd(sniffer_pkg::OP_REG_WRITE, 6'(a), 8'(v));
                end
                "R": begin
                    void'($sscanf(line, "R %h %h", a, v));
                    wait_bytes(exp_q.size(), "register read"); // Older frames first
                    send_cmd(sniffer_pkg::OP_REG_READ, 6'(a), 8'h00);
                    exp_q.push_back(sniffer_pkg::TAG_REG);
                    exp_q.push_back(8'(v));
                    check("phy register array", v, phy_regs[6'(a)]);
                end
                "C": begin
                    void'($sscanf(line, "C %s", tok));
                    cap_on = (tok == "on");
                    send_cmd(cap_on ? sniffer_pkg::OP_CAPTURE_ON
                                    : sniffer_pkg::OP_CAPTURE_OFF, 6'd0, 8'h00);
                end
                "P": begin
                    void'($sscanf(line, "P %d %h %h %h %h", n, pb[0], pb[1], pb[2], pb[3]));
                    pkt_q.push_back({1'b0, RXCMD_OPEN});
                    for (int i = 0; i < n && i < 4; i++)
                        pkt_q.push_back({1'b1, pb[i]});
                    pkt_q.push_back({1'b0, RXCMD_CLOSE});
                    if (cap_on) begin
                        exp_q.push_back(sniffer_pkg::TAG_RXCMD);
                        exp_q.push_back(RXCMD_OPEN);
                        for (int i = 0; i < n && i < 4; i++) begin
                            exp_q.push_back(sniffer_pkg::TAG_DATA);
                            exp_q.push_back(pb[i]);
                        end
                        exp_q.push_back(sniffer_pkg::TAG_RXCMD);
                        exp_q.push_back(RXCMD_CLOSE);
                    end
                    wait_phy_idle();
                    idle_gap();
                end
                "E": begin
                    void'($sscanf(line, "E %d %s", n, tname));
                    finish_test(tname, n);
                end
                default: ;  // Comment or blank line
            endcase
        end
        if (fd != 0)
            $fclose(fd);
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0 && !abort) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
